/* Bender.yml */
package:
  name: tilemap

sources:
  - include_dirs:
      - logic
    files:
      - logic/tilemap_pkg.sv
      - logic/tilemap_regs.sv
      - logic/raster_timing.sv
      - logic/tile_fetch.sv
      - logic/pixel_shifter.sv
      - logic/layer_mixer.sv
      - logic/tilemap_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/tilemap_assertions.sv
      - dv/tilemap_tb.sv

/* compile.f */
+incdir+logic
logic/tilemap_pkg.sv
logic/tilemap_regs.sv
logic/raster_timing.sv
logic/tile_fetch.sv
logic/pixel_shifter.sv
logic/layer_mixer.sv
logic/tilemap_top.sv
dv/tilemap_assertions.sv
dv/tilemap_tb.sv

/* dv/tilemap_assertions.sv */
`timescale 1ns/1ps

module tilemap_assertions (
    input logic                    clk,
    input logic                    reset,
    input logic                    load,
    input tilemap_pkg::raster_t    raster,
    input tilemap_pkg::video_out_t video
);

    int failures = 0;

    // Shifters only take a row on a pixel enable
    load_on_pixel_ce: assert property (
        @(posedge clk) disable iff (reset) load |-> raster.pixel_ce
    ) else begin
        $error("load asserted without pixel_ce");
        failures++;
    end

    blank_is_black: assert property (
        @(posedge clk) disable iff (reset)
        (video.hblank || video.vblank) |-> (video.color == 8'd0)
    ) else begin
        $error("nonzero color during blanking");
        failures++;
    end

    pixel_ce_period: assert property (
        @(posedge clk) disable iff (reset)
        raster.pixel_ce |=> !raster.pixel_ce ##1 raster.pixel_ce
    ) else begin
        $error("pixel_ce pulses not two clocks apart");
        failures++;
    end

endmodule

bind tilemap_top tilemap_assertions u_assertions (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .raster (raster),
    .video  (video)
);

/* dv/tilemap_tb.sv */
`timescale 1ns/1ps
`include "tilemap_consts.svh"

module tilemap_tb;

    localparam int NUM_TESTS  = 14;
    localparam int H_BLANK    = `TM_H_TOTAL - `TM_H_ACTIVE;
    localparam int LINE_CLKS  = 2 * `TM_H_TOTAL;
    localparam int FRAME_CLKS = LINE_CLKS * `TM_V_TOTAL;
    localparam int MAP_PIX    = 8 * `TM_MAP_DIM;
    localparam int SEL_VBLANK = 0;
    localparam int SEL_HBLANK = 1;

    typedef struct packed {
        logic [15:0] bg_x;
        logic [15:0] bg_y;
        logic [15:0] fg_x;
        logic [15:0] fg_y;
        logic [15:0] ctrl;
        logic [8:0]  line;
        logic [8:0]  npix;
    } test_vec_t;

    logic                    clk;
    logic                    reset;
    logic                    reg_we;
    logic [2:0]              reg_addr;
    logic [15:0]             reg_wdata;
    logic [15:0]             reg_rdata;
    logic [12:0]             tile_ram_addr;
    logic [15:0]             tile_ram_data;
    logic [14:0]             gfx_rom_addr;
    logic [31:0]             gfx_rom_data;
    tilemap_pkg::video_out_t video;

    logic [15:0] tile_ram [8192];
    logic [31:0] gfx_rom [32768];
    logic [12:0] ram_addr_q;
    logic [14:0] rom_addr_q;
    test_vec_t   tests [NUM_TESTS];
    logic [15:0] cur_regs [5];
    logic        timed_out;
    int          pass_count;
    int          fail_count;

    tilemap_top u_dut (
        .clk           (clk),
        .reset         (reset),
        .reg_we        (reg_we),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .tile_ram_addr (tile_ram_addr),
        .tile_ram_data (tile_ram_data),
        .gfx_rom_addr  (gfx_rom_addr),
        .gfx_rom_data  (gfx_rom_data),
        .video         (video)
    );

    always #10 clk = ~clk;

    // Memories answer one clock after the address
    always begin
        @(posedge clk);
        #1;
        tile_ram_data = tile_ram[ram_addr_q];
        gfx_rom_data  = gfx_rom[rom_addr_q];
        ram_addr_q    = tile_ram_addr;
        rom_addr_q    = gfx_rom_addr;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic fill_memories();
        logic [31:0] w;
        for (int a = 0; a < 8192; a++) begin
            tile_ram[a] = 16'($urandom);
        end
        // About a quarter of the pixels are transparent
        for (int a = 0; a < 32768; a++) begin
            w = $urandom;
            for (int n = 0; n < 8; n++) begin
                if ($urandom % 4 == 0) begin
                    w[4 * n +: 4] = 4'd0;
                end
            end
            gfx_rom[a] = w;
        end
    endtask

    task automatic load_table();
        // bg_x, bg_y, fg_x, fg_y, ctrl, line, pixels
        tests[0]  = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 9'd0, 9'd320};
        tests[1]  = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 9'd7, 9'd320};
        tests[2]  = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 9'd100, 9'd320};
        tests[3]  = '{16'h0003, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 9'd20, 9'd320};
        tests[4]  = '{16'h0008, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 9'd33, 9'd320};
        tests[5]  = '{16'hA1FD, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 9'd50, 9'd320};
        tests[6]  = '{16'h0000, 16'h0005, 16'h0000, 16'h0005, 16'h0000, 9'd10, 9'd320};
        tests[7]  = '{16'h0000, 16'h00FA, 16'h0000, 16'h00FA, 16'h0000, 9'd200, 9'd320};
        tests[8]  = '{16'h0000, 16'h00FA, 16'h0007, 16'h01F0, 16'h0000, 9'd100, 9'd320};
        tests[9]  = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0002, 9'd60, 9'd320};
        tests[10] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0001, 9'd61, 9'd320};
        tests[11] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0003, 9'd62, 9'd320};
        tests[12] = '{16'h0003, 16'h0000, 16'h0005, 16'h0000, 16'h0004, 9'd90, 9'd320};
        tests[13] = '{16'h012C, 16'h0011, 16'h307B, 16'h004D, 16'hFFF8, 9'd150, 9'd160};
    endtask

    // Palette and pixel of one layer at screen x, y
    function automatic logic [7:0] layer_dot(input int base, input int sx, input int sy,
                                             input int x, input int y);
        int          mx;
        int          my;
        int          gaddr;
        logic [15:0] word;
        logic [31:0] row;
        mx    = (x + sx) % MAP_PIX;
        my    = (y + sy) % MAP_PIX;
        word  = tile_ram[base + (my / 8) * `TM_MAP_DIM + mx / 8];
        gaddr = word[11:0] * 8 + my % 8;
        row   = gfx_rom[gaddr];
        return {word[15:12], row[4 * (7 - mx % 8) +: 4]};
    endfunction

    function automatic logic [7:0] expected_color(input int x, input int y);
        logic [7:0] bg;
        logic [7:0] fg;
        logic       bg_on;
        logic       fg_on;
        bg    = layer_dot(0, cur_regs[0][8:0], cur_regs[1][8:0], x, y);
        fg    = layer_dot(`TM_FG_BASE, cur_regs[2][8:0], cur_regs[3][8:0], x, y);
        bg_on = !cur_regs[4][0] && (bg[3:0] != 4'd0);
        fg_on = !cur_regs[4][1] && (fg[3:0] != 4'd0);
        if (cur_regs[4][2] && bg_on) begin
            return bg;
        end
        if (fg_on) begin
            return fg;
        end
        if (bg_on) begin
            return bg;
        end
        return 8'd0;
    endfunction

    function automatic logic flag_value(input int sel);
        return (sel == SEL_VBLANK) ? video.vblank : video.hblank;
    endfunction

    task automatic wait_flag(input int sel, input logic level, input int limit,
                             input string what);
        int n;
        n = 0;
        while (!timed_out && flag_value(sel) !== level) begin
            if (n == limit) begin
                $display("timeout: %s did not arrive within %0d clocks", what, limit);
                timed_out = 1'b1;
            end else begin
                step();
                n++;
            end
        end
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [15:0] data);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        step();
        reg_we    = 1'b0;
    endtask

    // Active pixels against the model, then the blanking that follows
    task automatic scan_line(input int y, input int npix, inout int bad);
        int         x;
        int         blanks;
        int         n;
        logic [7:0] want;
        x      = 0;
        blanks = 0;
        n      = 0;
        while (!timed_out && (x < `TM_H_ACTIVE || blanks < H_BLANK)) begin
            if (video.pixel_ce && !video.hblank) begin
                if (x < npix) begin
                    want = expected_color(x, y);
                    assert (video.color === want) else begin
                        $display("error: %0t video.color x=%0d y=%0d expected %02h got %02h",
                                 $time, x, y, want, video.color);
                        bad++;
                    end
                end
                x++;
            end else if (video.pixel_ce) begin
                assert (video.color === 8'd0) else begin
                    $display("error: %0t video.color in hblank expected 00 got %02h",
                             $time, video.color);
                    bad++;
                end
                blanks++;
            end
            if (n == 2 * LINE_CLKS) begin
                $display("timeout: line %0d did not finish within %0d clocks", y, n);
                timed_out = 1'b1;
            end else begin
                step();
                n++;
            end
        end
    endtask

    task automatic run_test(input int idx);
        test_vec_t   t;
        logic [15:0] vals [5];
        int          bad;
        t    = tests[idx];
        vals = '{t.bg_x, t.bg_y, t.fg_x, t.fg_y, t.ctrl};
        bad  = 0;
        for (int a = 0; a < 5; a++) begin
            write_reg(3'(a), vals[a]);
            cur_regs[a] = vals[a];
        end
        for (int a = 0; a < 5; a++) begin
            reg_addr = 3'(a);
            step();
            assert (reg_rdata === vals[a]) else begin
                $display("error: %0t reg_rdata[%0d] expected %04h got %04h",
                         $time, a, vals[a], reg_rdata);
                bad++;
            end
        end
        // A full frame with the new registers starts after vblank
        wait_flag(SEL_VBLANK, 1'b1, 2 * FRAME_CLKS, "vblank start");
        wait_flag(SEL_VBLANK, 1'b0, FRAME_CLKS, "vblank end");
        for (int l = 0; l < t.line; l++) begin
            wait_flag(SEL_HBLANK, 1'b0, 2 * LINE_CLKS, "active video");
            wait_flag(SEL_HBLANK, 1'b1, 2 * LINE_CLKS, "hblank");
        end
        wait_flag(SEL_HBLANK, 1'b0, 2 * LINE_CLKS, "target line");
        if (!timed_out) begin
            scan_line(t.line, t.npix, bad);
        end
        if (bad == 0 && !timed_out) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d line %0d: %0d pixels, %0d mismatches, %s", idx, t.line, t.npix,
                 bad, (bad == 0 && !timed_out) ? "ok" : "FAIL");
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        reg_we     = 1'b0;
        reg_addr   = 3'd0;
        reg_wdata  = 16'd0;
        ram_addr_q = '0;
        rom_addr_q = '0;
        timed_out  = 1'b0;
        pass_count = 0;
        fail_count = 0;
        tile_ram_data = 16'd0;
        gfx_rom_data  = 32'd0;
        void'($urandom(32'h21862d4b));
        fill_memories();
        load_table();
        repeat (10) begin
            step();
        end
        reset = 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (!timed_out) begin
                run_test(i);
            end
        end
        $display("%0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && !timed_out && u_dut.u_assertions.failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* logic/layer_mixer.sv */
`timescale 1ns/1ps

module layer_mixer (
    input  logic                    clk,
    input  logic                    reset,
    input  tilemap_pkg::raster_t    raster,
    input  tilemap_pkg::scroll_t    scroll,
    input  tilemap_pkg::dot_t       bg_dot,
    input  tilemap_pkg::dot_t       fg_dot,
    output tilemap_pkg::video_out_t video
);

    tilemap_pkg::dot_t front;
    tilemap_pkg::dot_t back;
    logic              bg_opaque;
    logic              fg_opaque;
    logic              front_opaque;
    logic              back_opaque;
    logic [7:0]        mix_color;

    always_comb begin
        bg_opaque = scroll.bg_en && (bg_dot.pixel != 4'd0);
        fg_opaque = scroll.fg_en && (fg_dot.pixel != 4'd0);
        // Foreground is in front unless the swap is set
        if (scroll.bg_prio) begin
            front        = bg_dot;
            front_opaque = bg_opaque;
            back         = fg_dot;
            back_opaque  = fg_opaque;
        end else begin
            front        = fg_dot;
            front_opaque = fg_opaque;
            back         = bg_dot;
            back_opaque  = bg_opaque;
        end

        if (raster.hblank || raster.vblank) begin
            mix_color = '0;
        end else if (front_opaque) begin
            mix_color = {front.palette, front.pixel};
        end else if (back_opaque) begin
            mix_color = {back.palette, back.pixel};
        end else begin
            mix_color = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            video <= '{color: 8'd0, pixel_ce: 1'b0, hblank: 1'b1, vblank: 1'b1};
        end else begin
            video <= '{color: mix_color, pixel_ce: raster.pixel_ce,
                       hblank: raster.hblank, vblank: raster.vblank};
        end
    end

endmodule

/* logic/pixel_shifter.sv */
`timescale 1ns/1ps

module pixel_shifter (
    input  logic                   clk,
    input  logic                   pixel_ce,
    input  logic                   load,
    input  logic [2:0]             tap,
    input  tilemap_pkg::tile_row_t row,
    output tilemap_pkg::dot_t      dot
);

    localparam int DEPTH = 16;

    tilemap_pkg::dot_t shift_q [DEPTH];

    // Entry 15 is the oldest dot; fine scroll reads further down
    assign dot = shift_q[4'(DEPTH - 1) - {1'b0, tap}];

    always_ff @(posedge clk) begin
        if (pixel_ce) begin
            for (int i = DEPTH - 1; i > 0; i--) begin
                shift_q[i] <= shift_q[i - 1];
            end
            shift_q[0] <= '0;
            if (load) begin
                // Leftmost pixel lands in entry 7
                for (int i = 0; i < 8; i++) begin
                    shift_q[i] <= '{palette: row.palette, pixel: row.gfx[4 * i +: 4]};
                end
            end
        end
    end

endmodule

/* logic/raster_timing.sv */
`timescale 1ns/1ps
`include "tilemap_consts.svh"

module raster_timing (
    input  logic                 clk,
    input  logic                 reset,
    output tilemap_pkg::raster_t raster
);

    logic       phase_q;
    logic [8:0] hcnt_q;
    logic [8:0] vcnt_q;
    logic       line_end;

    assign line_end = phase_q && (hcnt_q == 9'(`TM_H_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            phase_q <= 1'b0;
            hcnt_q  <= '0;
            vcnt_q  <= '0;
        end else begin
            phase_q <= ~phase_q;
            if (line_end) begin
                hcnt_q <= '0;
                if (vcnt_q == 9'(`TM_V_TOTAL - 1)) begin
                    vcnt_q <= '0;
                end else begin
                    vcnt_q <= vcnt_q + 9'd1;
                end
            end else if (phase_q) begin
                hcnt_q <= hcnt_q + 9'd1;
            end
        end
    end

    always_comb begin
        raster.hcnt     = hcnt_q;
        raster.vcnt     = vcnt_q;
        raster.pixel_ce = phase_q;
        raster.hblank   = (hcnt_q < 9'(`TM_H_ACTIVE_START)) ||
                          (hcnt_q >= 9'(`TM_H_ACTIVE_START + `TM_H_ACTIVE));
        raster.vblank   = vcnt_q >= 9'(`TM_V_ACTIVE);
        // Two clocks per pixel, eight pixels per column
        raster.slot     = {hcnt_q[2:0], phase_q};
    end

endmodule

/* logic/tile_fetch.sv */
`timescale 1ns/1ps
`include "tilemap_consts.svh"

module tile_fetch (
    input  logic                   clk,
    input  logic                   reset,
    input  tilemap_pkg::raster_t   raster,
    input  tilemap_pkg::scroll_t   scroll,
    output logic [12:0]            tile_ram_addr,
    input  logic [15:0]            tile_ram_data,
    output logic [14:0]            gfx_rom_addr,
    input  logic [31:0]            gfx_rom_data,
    output tilemap_pkg::tile_row_t bg_row,
    output tilemap_pkg::tile_row_t fg_row,
    output logic                   load
);

    tilemap_pkg::fetch_slot_e op;
    logic [8:0]  col_x;
    logic [8:0]  bg_px;
    logic [8:0]  bg_py;
    logic [8:0]  fg_px;
    logic [8:0]  fg_py;
    logic [12:0] bg_map_addr;
    logic [12:0] fg_map_addr;
    logic [15:0] bg_word;
    logic [15:0] fg_word;
    logic        in_window;
    logic        row_ready;

    function automatic logic [12:0] map_addr(input logic [12:0] base,
                                             input logic [8:0]  px,
                                             input logic [8:0]  py);
        logic [12:0] row_ofs;
        row_ofs = 13'(py[8:3]) * 13'(`TM_MAP_DIM);
        return base + row_ofs + 13'(px[8:3]);
    endfunction

    always_comb begin
        case (raster.slot)
            4'd0:                   op = tilemap_pkg::BG_CODE_ADDR;
            4'd1:                   op = tilemap_pkg::BG_CODE_TAKE;
            4'd2:                   op = tilemap_pkg::FG_CODE_ADDR;
            4'd3:                   op = tilemap_pkg::FG_CODE_TAKE;
            4'd4:                   op = tilemap_pkg::BG_GFX_ADDR;
            4'd5:                   op = tilemap_pkg::BG_GFX_TAKE;
            4'd6:                   op = tilemap_pkg::FG_GFX_ADDR;
            4'd7:                   op = tilemap_pkg::FG_GFX_TAKE;
            4'(`TM_SLOT_LEN - 1):   op = tilemap_pkg::LOAD_SLOT;
            default:                op = tilemap_pkg::IDLE_SLOT;
        endcase
    end

    // Screen x of the column this fetch feeds, two columns later
    assign col_x = {raster.hcnt[8:3], 3'b000} - 9'(`TM_H_FETCH_START);

    // 9-bit sums wrap at 512 pixels, which is the 64-tile map
    assign bg_px = col_x + scroll.bg_x;
    assign bg_py = raster.vcnt + scroll.bg_y;
    assign fg_px = col_x + scroll.fg_x;
    assign fg_py = raster.vcnt + scroll.fg_y;

    assign bg_map_addr = map_addr(13'd0, bg_px, bg_py);
    assign fg_map_addr = map_addr(13'(`TM_FG_BASE), fg_px, fg_py);

    assign in_window = (raster.hcnt >= 9'(`TM_H_FETCH_START)) &&
                       (raster.hcnt < 9'(`TM_H_ACTIVE_START + `TM_H_ACTIVE));

    // Addresses go out on even slots, the memories answer on the odd one
    assign tile_ram_addr = (op == tilemap_pkg::FG_CODE_ADDR) ? fg_map_addr : bg_map_addr;
    assign gfx_rom_addr  = (op == tilemap_pkg::FG_GFX_ADDR) ?
                           {fg_word[11:0], fg_py[2:0]} :
                           {bg_word[11:0], bg_py[2:0]};

    always_ff @(posedge clk) begin
        case (op)
            tilemap_pkg::BG_CODE_TAKE: begin
                bg_word <= tile_ram_data;
            end
            tilemap_pkg::FG_CODE_TAKE: begin
                fg_word <= tile_ram_data;
            end
            tilemap_pkg::BG_GFX_TAKE: begin
                bg_row <= '{palette: bg_word[15:12], gfx: gfx_rom_data};
            end
            tilemap_pkg::FG_GFX_TAKE: begin
                fg_row <= '{palette: fg_word[15:12], gfx: gfx_rom_data};
            end
            default: begin
            end
        endcase
    end

    // Set once both rows of a visible column have landed
    always_ff @(posedge clk) begin
        if (reset) begin
            row_ready <= 1'b0;
        end else if (op == tilemap_pkg::FG_GFX_TAKE) begin
            row_ready <= in_window;
        end else if (op == tilemap_pkg::LOAD_SLOT) begin
            row_ready <= 1'b0;
        end
    end

    assign load = (op == tilemap_pkg::LOAD_SLOT) && row_ready;

endmodule

/* logic/tilemap_consts.svh */
`ifndef TILEMAP_CONSTS_SVH
`define TILEMAP_CONSTS_SVH

// Raster geometry in pixels and lines
`define TM_H_TOTAL 424
`define TM_H_ACTIVE 320
`define TM_V_TOTAL 262
`define TM_V_ACTIVE 224

// Fetching runs two columns ahead of the visible window
`define TM_H_FETCH_START 16
`define TM_H_ACTIVE_START 32

// Tiles per map side
`define TM_MAP_DIM 64

// Tile RAM word address of the foreground map
`define TM_FG_BASE 4096

// Clocks per 8-pixel column
`define TM_SLOT_LEN 16

`endif

/* logic/tilemap_pkg.sv */
package tilemap_pkg;

    // Decoded control register state
    typedef struct packed {
        logic [8:0] bg_x;
        logic [8:0] bg_y;
        logic [8:0] fg_x;
        logic [8:0] fg_y;
        logic       bg_en;
        logic       fg_en;
        logic       bg_prio;
    } scroll_t;

    typedef struct packed {
        logic [8:0] hcnt;
        logic [8:0] vcnt;
        logic       pixel_ce;
        logic       hblank;
        logic       vblank;
        logic [3:0] slot;
    } raster_t;

    // One opcode per clock of a column
    typedef enum logic [3:0] {
        BG_CODE_ADDR,
        BG_CODE_TAKE,
        FG_CODE_ADDR,
        FG_CODE_TAKE,
        BG_GFX_ADDR,
        BG_GFX_TAKE,
        FG_GFX_ADDR,
        FG_GFX_TAKE,
        IDLE_SLOT,
        LOAD_SLOT
    } fetch_slot_e;

    // Leftmost pixel sits in gfx[31:28]
    typedef struct packed {
        logic [3:0]  palette;
        logic [31:0] gfx;
    } tile_row_t;

    typedef struct packed {
        logic [3:0] palette;
        logic [3:0] pixel;
    } dot_t;

    typedef struct packed {
        logic [7:0] color;
        logic       pixel_ce;
        logic       hblank;
        logic       vblank;
    } video_out_t;

endpackage

/* logic/tilemap_regs.sv */
`timescale 1ns/1ps

module tilemap_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 reg_we,
    input  logic [2:0]           reg_addr,
    input  logic [15:0]          reg_wdata,
    output logic [15:0]          reg_rdata,
    output tilemap_pkg::scroll_t scroll
);

    localparam int NUM_REGS = 5;

    logic [15:0] regs_q [NUM_REGS];
    logic        addr_ok;

    assign addr_ok = reg_addr < 3'(NUM_REGS);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (reg_we && addr_ok) begin
            regs_q[reg_addr] <= reg_wdata;
        end
    end

    // Unmapped addresses read as zero
    assign reg_rdata = addr_ok ? regs_q[reg_addr] : '0;

    assign scroll.bg_x    = regs_q[0][8:0];
    assign scroll.bg_y    = regs_q[1][8:0];
    assign scroll.fg_x    = regs_q[2][8:0];
    assign scroll.fg_y    = regs_q[3][8:0];
    // Control bits are disables, so a cleared register shows both layers
    assign scroll.bg_en   = ~regs_q[4][0];
    assign scroll.fg_en   = ~regs_q[4][1];
    assign scroll.bg_prio = regs_q[4][2];

endmodule

/* logic/tilemap_top.sv */
`timescale 1ns/1ps

module tilemap_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    reg_we,
    input  logic [2:0]              reg_addr,
    input  logic [15:0]             reg_wdata,
    output logic [15:0]             reg_rdata,
    output logic [12:0]             tile_ram_addr,
    input  logic [15:0]             tile_ram_data,
    output logic [14:0]             gfx_rom_addr,
    input  logic [31:0]             gfx_rom_data,
    output tilemap_pkg::video_out_t video
);

    tilemap_pkg::scroll_t   scroll;
    tilemap_pkg::raster_t   raster;
    tilemap_pkg::tile_row_t bg_row;
    tilemap_pkg::tile_row_t fg_row;
    tilemap_pkg::dot_t      bg_dot;
    tilemap_pkg::dot_t      fg_dot;
    logic                   load;

    tilemap_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .scroll    (scroll)
    );

    raster_timing u_timing (
        .clk    (clk),
        .reset  (reset),
        .raster (raster)
    );

    tile_fetch u_fetch (
        .clk           (clk),
        .reset         (reset),
        .raster        (raster),
        .scroll        (scroll),
        .tile_ram_addr (tile_ram_addr),
        .tile_ram_data (tile_ram_data),
        .gfx_rom_addr  (gfx_rom_addr),
        .gfx_rom_data  (gfx_rom_data),
        .bg_row        (bg_row),
        .fg_row        (fg_row),
        .load          (load)
    );

    // Fine scroll comes straight from the low X bits
    pixel_shifter u_bg_shift (
        .clk      (clk),
        .pixel_ce (raster.pixel_ce),
        .load     (load),
        .tap      (scroll.bg_x[2:0]),
        .row      (bg_row),
        .dot      (bg_dot)
    );

    pixel_shifter u_fg_shift (
        .clk      (clk),
        .pixel_ce (raster.pixel_ce),
        .load     (load),
        .tap      (scroll.fg_x[2:0]),
        .row      (fg_row),
        .dot      (fg_dot)
    );

    layer_mixer u_mixer (
        .clk    (clk),
        .reset  (reset),
        .raster (raster),
        .scroll (scroll),
        .bg_dot (bg_dot),
        .fg_dot (fg_dot),
        .video  (video)
    );

endmodule
